// ==== verilog/dp_macros.svh ====
// shared constants for the 8-bit datapath
// RESET_P keeps I and bit 5 set; the stack always sits in page STACK_PAGE
`ifndef DP_MACROS_SVH
`define DP_MACROS_SVH

// width of every programmer register and data port
`define DATA_W 8

// program counter value after reset
`define RESET_PC 16'h0200

// status after reset, NV-BDIZC with I and bit 5 set
`define RESET_P 8'h24

// high address byte used for push and pull
`define STACK_PAGE 8'h01

`endif

// ==== verilog/dpPkg.sv ====
// command word layout and control bundles shared by the datapath units
// both command views are 16 bits; the kind field sits in bits 15:14 of each
`include "dp_macros.svh"

package dpPkg;

	typedef enum logic [1:0] {KIND_ALU, KIND_XFER, KIND_MEM, KIND_FLOW} cmdKind_e;

	typedef enum logic [2:0] {OP_ADC, OP_SBC, OP_AND, OP_EOR, OP_ORA, OP_LSR} aluOp_e;

	typedef enum logic [1:0] {REG_A, REG_X, REG_Y, REG_S} regSel_e;

	// operand source for the ALU and for operand loads
	typedef enum logic [1:0] {SRC_IMM, SRC_DATA, SRC_X, SRC_Y} srcSel_e;

	// what the register bank writes
	typedef enum logic [1:0] {RSRC_ALU, RSRC_OPND, RSRC_REG} regSrc_e;

	// sub-operations of the non-ALU view
	localparam logic [1:0] XF_LOAD = 2'd0;
	localparam logic [1:0] XF_FROM_A = 2'd1;
	localparam logic [1:0] XF_FROM_S = 2'd2;
	localparam logic [1:0] MEM_STORE = 2'd0;
	localparam logic [1:0] MEM_PUSH = 2'd1;
	localparam logic [1:0] MEM_PULL = 2'd2;
	localparam logic [1:0] FL_INC = 2'd0;
	localparam logic [1:0] FL_JUMP = 2'd1;
	localparam logic [1:0] FL_SET = 2'd2;
	localparam logic [1:0] FL_CLR = 2'd3;

	typedef struct packed {
		cmdKind_e kind;
		aluOp_e aluOp;
		srcSel_e srcSel;
		logic spare;
		logic [`DATA_W-1:0] imm;
	} aluCmd_s;

	typedef struct packed {
		cmdKind_e kind;
		logic [1:0] subOp;
		regSel_e dstReg;
		srcSel_e srcSel;
		logic [`DATA_W-1:0] imm;
	} xferCmd_s;

	// one command word, read through whichever view its kind selects
	typedef union packed {
		aluCmd_s alu;
		xferCmd_s xfer;
	} cmdWord_u;

	typedef struct packed {
		aluOp_e op;
		srcSel_e srcSel;
		logic carryIn;
		logic decimal;
		logic [`DATA_W-1:0] imm;
	} aluCtl_s;

	typedef struct packed {
		logic we;
		regSel_e dstReg;
		regSrc_e src;
		regSel_e srcReg;
		logic push;
		logic pull;
	} regCtl_s;

	// vValid is set only by add and subtract
	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
		logic vValid;
	} aluFlags_s;

	typedef struct packed {
		logic aluUpd;
		logic loadUpd;
		logic setC;
		logic clrC;
		logic setD;
		logic clrD;
		logic clrV;
	} flagCtl_s;

endpackage

// ==== verilog/microSequencer.sv ====
// decodes one command word per strobe into single-cycle control bundles
// strobes are ignored until reset has been released for one clock
`timescale 1ns/10ps

module microSequencer import dpPkg::*; (
	input logic ld,
	input logic rstN,
	input logic cmdStrobe,
	input cmdWord_u cmd,
	input logic flagC,
	input logic flagD,
	output aluCtl_s aluCtl,
	output regCtl_s regCtl,
	output flagCtl_s flagCtl,
	output logic pcInc,
	output logic pcJump,
	output logic memWrite,
	output logic memPush
);

	logic live;
	logic go;
	logic [1:0] subOp;
	regSel_e dst;

	// arms one edge after reset is released
	always_ff @(posedge ld) begin
		if (!rstN)
			live <= 1'b0;
		else
			live <= 1'b1;
	end

	assign go = cmdStrobe & live;
	assign subOp = cmd.xfer.subOp;
	assign dst = cmd.xfer.dstReg;

	always_comb begin
		// ALU view by default, carry and decimal come from the live flags
		aluCtl.op = cmd.alu.aluOp;
		aluCtl.srcSel = cmd.alu.srcSel;
		aluCtl.carryIn = flagC;
		aluCtl.decimal = flagD & (cmd.alu.aluOp == OP_ADC);
		aluCtl.imm = cmd.alu.imm;
		regCtl = '0;
		regCtl.dstReg = dst;
		regCtl.src = RSRC_ALU;
		regCtl.srcReg = REG_A;
		flagCtl = '0;
		pcInc = 1'b0;
		pcJump = 1'b0;
		memWrite = 1'b0;
		memPush = 1'b0;
		case (cmd.alu.kind)
			KIND_ALU: begin
				// result always lands in A
				regCtl.we = go;
				regCtl.dstReg = REG_A;
				flagCtl.aluUpd = go;
			end
			KIND_XFER: begin
				aluCtl.srcSel = cmd.xfer.srcSel;
				regCtl.we = go;
				case (subOp)
					XF_LOAD: begin
						// X or Y as source means a register copy
						if (cmd.xfer.srcSel == SRC_X || cmd.xfer.srcSel == SRC_Y) begin
							regCtl.src = RSRC_REG;
							regCtl.srcReg = (cmd.xfer.srcSel == SRC_X) ? REG_X : REG_Y;
						end else begin
							regCtl.src = RSRC_OPND;
						end
					end
					XF_FROM_A: begin
						regCtl.src = RSRC_REG;
						regCtl.srcReg = REG_A;
					end
					XF_FROM_S: begin
						regCtl.src = RSRC_REG;
						regCtl.srcReg = REG_S;
					end
					default: regCtl.we = 1'b0;
				endcase
				// writes to S keep the flags
				flagCtl.loadUpd = regCtl.we & (dst != REG_S);
			end
			KIND_MEM: begin
				// stored or pushed byte is read through the register mux
				regCtl.src = RSRC_REG;
				regCtl.srcReg = dst;
				case (subOp)
					MEM_STORE: memWrite = go;
					MEM_PUSH: begin
						memPush = go;
						regCtl.push = go;
					end
					MEM_PULL: begin
						aluCtl.srcSel = SRC_DATA;
						regCtl.src = RSRC_OPND;
						regCtl.we = go;
						regCtl.pull = go;
						flagCtl.loadUpd = go & (dst != REG_S);
					end
					default: ;
				endcase
			end
			default: begin
				// flow, imm bits pick C, D and V
				case (subOp)
					FL_INC: pcInc = go;
					FL_JUMP: pcJump = go;
					FL_SET: begin
						flagCtl.setC = go & cmd.xfer.imm[0];
						flagCtl.setD = go & cmd.xfer.imm[1];
					end
					default: begin
						flagCtl.clrC = go & cmd.xfer.imm[0];
						flagCtl.clrD = go & cmd.xfer.imm[1];
						flagCtl.clrV = go & cmd.xfer.imm[2];
					end
				endcase
			end
		endcase
	end

endmodule

// ==== verilog/aluUnit.sv ====
// purely combinational ALU on A and one selected operand
// decimal adjust is applied to ADC only, SBC in decimal mode stays binary
`timescale 1ns/10ps
`include "dp_macros.svh"

module aluUnit import dpPkg::*; (
	input aluCtl_s aluCtl,
	input logic [`DATA_W-1:0] acc,
	input logic [`DATA_W-1:0] regX,
	input logic [`DATA_W-1:0] regY,
	input logic [`DATA_W-1:0] dataIn,
	output logic [`DATA_W-1:0] result,
	output aluFlags_s flags
);

	logic [`DATA_W-1:0] opnd;
	logic [`DATA_W-1:0] opB;
	logic [4:0] loSum;
	logic [4:0] hiSum;
	logic [`DATA_W-1:0] binSum;
	logic [`DATA_W-1:0] adjLo;
	logic decCarry;
	logic carryOut;

	// operand select
	always_comb begin
		case (aluCtl.srcSel)
			SRC_IMM: opnd = aluCtl.imm;
			SRC_DATA: opnd = dataIn;
			SRC_X: opnd = regX;
			default: opnd = regY;
		endcase
	end

	// subtract is add of the inverted operand, carry acts as not-borrow
	assign opB = (aluCtl.op == OP_SBC) ? ~opnd : opnd;

	// two nibble steps so the half carry is visible
	assign loSum = {1'b0, acc[3:0]} + {1'b0, opB[3:0]} + {4'b0, aluCtl.carryIn};
	assign hiSum = {1'b0, acc[7:4]} + {1'b0, opB[7:4]} + {4'b0, loSum[4]};
	assign binSum = {hiSum[3:0], loSum[3:0]};

	// low digit fix when over 9 or half carry
	assign adjLo = (loSum[3:0] > 4'd9 || loSum[4]) ? binSum + 8'h06 : binSum;
	// high digit fix, also the decimal carry
	assign decCarry = hiSum[4] | (binSum > 8'h99);

	always_comb begin
		result = binSum;
		carryOut = aluCtl.carryIn;
		case (aluCtl.op)
			OP_ADC: begin
				if (aluCtl.decimal) begin
					result = decCarry ? adjLo + 8'h60 : adjLo;
					carryOut = decCarry;
				end else begin
					carryOut = hiSum[4];
				end
			end
			OP_SBC: carryOut = hiSum[4];
			OP_AND: result = acc & opnd;
			OP_EOR: result = acc ^ opnd;
			OP_ORA: result = acc | opnd;
			OP_LSR: begin
				// shifts A, bit 0 falls into C
				result = {1'b0, acc[7:1]};
				carryOut = acc[0];
			end
			default: result = acc;
		endcase
	end

	// logic ops hand C back unchanged through carryIn
	always_comb begin
		flags.n = result[7];
		flags.z = (result == '0);
		flags.c = carryOut;
		// same input signs, different result sign
		flags.v = (acc[7] == opB[7]) & (binSum[7] != acc[7]);
		flags.vValid = (aluCtl.op == OP_ADC) | (aluCtl.op == OP_SBC);
	end

endmodule

// ==== verilog/regBank.sv ====
// A, X, Y and the stack pointer; sp comes out of reset at FF
// a write to S wins over the push/pull step in the same cycle
`timescale 1ns/10ps
`include "dp_macros.svh"

module regBank import dpPkg::*; (
	input logic ld,
	input logic rstN,
	input regCtl_s regCtl,
	input logic [`DATA_W-1:0] aluResult,
	input logic [`DATA_W-1:0] operand,
	output logic [`DATA_W-1:0] acc,
	output logic [`DATA_W-1:0] regX,
	output logic [`DATA_W-1:0] regY,
	output logic [`DATA_W-1:0] sp,
	output logic [`DATA_W-1:0] loadValue
);

	logic [`DATA_W-1:0] regRead;

	// register read port for copies, stores and pushes
	always_comb begin
		case (regCtl.srcReg)
			REG_A: regRead = acc;
			REG_X: regRead = regX;
			REG_Y: regRead = regY;
			default: regRead = sp;
		endcase
	end

	// value to be written, also feeds N/Z and the memory data register
	always_comb begin
		case (regCtl.src)
			RSRC_ALU: loadValue = aluResult;
			RSRC_OPND: loadValue = operand;
			default: loadValue = regRead;
		endcase
	end

	always_ff @(posedge ld) begin
		if (!rstN) begin
			acc <= '0;
			regX <= '0;
			regY <= '0;
			sp <= '1;
		end else begin
			// push post-decrements, pull pre-increments
			if (regCtl.push)
				sp <= sp - 1'b1;
			else if (regCtl.pull)
				sp <= sp + 1'b1;
			if (regCtl.we) begin
				case (regCtl.dstReg)
					REG_A: acc <= loadValue;
					REG_X: regX <= loadValue;
					REG_Y: regY <= loadValue;
					default: sp <= loadValue;
				endcase
			end
		end
	end

endmodule

// ==== verilog/pcUnit.sv ====
// 16-bit program counter split into low and high bytes
// jump has priority over increment
`timescale 1ns/10ps
`include "dp_macros.svh"

module pcUnit (
	input logic ld,
	input logic rstN,
	input logic pcInc,
	input logic pcJump,
	input logic [2*`DATA_W-1:0] jumpAddr,
	output logic [2*`DATA_W-1:0] pc
);

	logic [`DATA_W-1:0] pcLo;
	logic [`DATA_W-1:0] pcHi;
	logic [`DATA_W-1:0] incLo;
	logic [`DATA_W-1:0] incHi;
	logic carryLo;

	// low byte incrementer, carry ripples into the high byte
	assign {carryLo, incLo} = {1'b0, pcLo} + 1'b1;
	assign incHi = pcHi + {{(`DATA_W-1){1'b0}}, carryLo};

	always_ff @(posedge ld) begin
		if (!rstN) begin
			{pcHi, pcLo} <= `RESET_PC;
		end else if (pcJump) begin
			{pcHi, pcLo} <= jumpAddr;
		end else if (pcInc) begin
			// FFFF wraps to 0000
			pcLo <= incLo;
			pcHi <= incHi;
		end
	end

	assign pc = {pcHi, pcLo};

endmodule

// ==== verilog/statusReg.sv ====
// NV-BDIZC flags; B and bit 5 always read as 1
// I is held at its reset value since no command changes it
`timescale 1ns/10ps
`include "dp_macros.svh"

module statusReg import dpPkg::*; (
	input logic ld,
	input logic rstN,
	input flagCtl_s flagCtl,
	input aluFlags_s aluFlags,
	input logic [`DATA_W-1:0] loadValue,
	output logic [`DATA_W-1:0] status
);

	// reset pattern as a vector so single flags can be picked out
	localparam logic [`DATA_W-1:0] RESET_STATUS = `RESET_P;

	logic flagN;
	logic flagV;
	logic flagD;
	logic flagZ;
	logic flagC;

	always_ff @(posedge ld) begin
		if (!rstN) begin
			flagN <= RESET_STATUS[7];
			flagV <= RESET_STATUS[6];
			flagD <= RESET_STATUS[3];
			flagZ <= RESET_STATUS[1];
			flagC <= RESET_STATUS[0];
		end else begin
			// ALU commands update V only for add and subtract
			if (flagCtl.aluUpd) begin
				flagN <= aluFlags.n;
				flagZ <= aluFlags.z;
				flagC <= aluFlags.c;
				if (aluFlags.vValid)
					flagV <= aluFlags.v;
			end
			// loads and pulls set N/Z from the written byte
			if (flagCtl.loadUpd) begin
				flagN <= loadValue[7];
				flagZ <= (loadValue == '0);
			end
			// explicit set and clear from flow commands
			if (flagCtl.setC)
				flagC <= 1'b1;
			else if (flagCtl.clrC)
				flagC <= 1'b0;
			if (flagCtl.setD)
				flagD <= 1'b1;
			else if (flagCtl.clrD)
				flagD <= 1'b0;
			if (flagCtl.clrV)
				flagV <= 1'b0;
		end
	end

	assign status = {flagN, flagV, 1'b1, 1'b1, flagD, RESET_STATUS[2], flagZ, flagC};

endmodule

// ==== verilog/datapathTop.sv ====
// datapath top, one command per strobe, no back-pressure
// dataWe pulses for one clock after a store or push is taken
`timescale 1ns/10ps
`include "dp_macros.svh"

module datapathTop import dpPkg::*; (
	input logic ld,
	input logic rstN,
	input logic cmdStrobe,
	input cmdWord_u cmd,
	input logic [`DATA_W-1:0] dataIn,
	output logic [2*`DATA_W-1:0] addrOut,
	output logic [`DATA_W-1:0] dataOut,
	output logic dataWe,
	output logic [`DATA_W-1:0] acc,
	output logic [`DATA_W-1:0] regX,
	output logic [`DATA_W-1:0] regY,
	output logic [`DATA_W-1:0] sp,
	output logic [2*`DATA_W-1:0] pc,
	output logic [`DATA_W-1:0] status
);

	aluCtl_s aluCtl;
	regCtl_s regCtl;
	flagCtl_s flagCtl;
	aluFlags_s aluFlags;
	logic pcInc;
	logic pcJump;
	logic memWrite;
	logic memPush;
	logic [`DATA_W-1:0] aluResult;
	logic [`DATA_W-1:0] operand;
	logic [`DATA_W-1:0] loadValue;

	microSequencer seq (
		.ld(ld), .rstN(rstN), .cmdStrobe(cmdStrobe), .cmd(cmd),
		.flagC(status[0]), .flagD(status[3]),
		.aluCtl(aluCtl), .regCtl(regCtl), .flagCtl(flagCtl),
		.pcInc(pcInc), .pcJump(pcJump), .memWrite(memWrite), .memPush(memPush)
	);

	aluUnit alu (
		.aluCtl(aluCtl), .acc(acc), .regX(regX), .regY(regY), .dataIn(dataIn),
		.result(aluResult), .flags(aluFlags)
	);

	// operand loads take imm or the data bus, X/Y copies go through the register mux
	assign operand = (aluCtl.srcSel == SRC_IMM) ? aluCtl.imm : dataIn;

	regBank regs (
		.ld(ld), .rstN(rstN), .regCtl(regCtl), .aluResult(aluResult), .operand(operand),
		.acc(acc), .regX(regX), .regY(regY), .sp(sp), .loadValue(loadValue)
	);

	// jump target is {dataIn, imm}
	pcUnit pcu (
		.ld(ld), .rstN(rstN), .pcInc(pcInc), .pcJump(pcJump),
		.jumpAddr({dataIn, aluCtl.imm}), .pc(pc)
	);

	statusReg flags (
		.ld(ld), .rstN(rstN), .flagCtl(flagCtl), .aluFlags(aluFlags),
		.loadValue(loadValue), .status(status)
	);

	always_ff @(posedge ld) begin
		if (!rstN)
			dataWe <= 1'b0;
		else
			dataWe <= memWrite | memPush;
	end

	// address and data only move when a write is taken
	always_ff @(posedge ld) begin
		if (memPush) begin
			// sp before its decrement
			addrOut <= {`STACK_PAGE, sp};
			dataOut <= loadValue;
		end else if (memWrite) begin
			// {imm, 00} plus X, the low byte never carries
			addrOut <= {aluCtl.imm, regX};
			dataOut <= loadValue;
		end
	end

endmodule

// ==== testbench/tbDatapath.sv ====
// self-checking testbench for datapathTop with one command strobed on every falling edge
// outputs are compared one cycle after each strobe; addrOut and dataOut only after writes
`timescale 1ns/10ps
`include "dp_macros.svh"

module tbDatapath import dpPkg::*; ();

	localparam int NUM_BIN = 40;
	localparam int NUM_DEC = 12;
	// setup, decimal framing, transfer, memory and flow commands
	localparam int NUM_FIXED = 35;
	localparam int NUM_CMDS = NUM_BIN + 3 * NUM_DEC + NUM_FIXED;
	localparam int CYCLE_LIMIT = 4 * NUM_CMDS + 50;

	// expected port state after one command
	typedef struct packed {
		logic [7:0] acc;
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] sp;
		logic [15:0] pc;
		logic [7:0] status;
		logic [15:0] addr;
		logic [7:0] dout;
		logic we;
	} modelState_s;

	logic ld;
	logic rstN;
	logic cmdStrobe;
	cmdWord_u cmd;
	logic [`DATA_W-1:0] dataIn;
	logic [2*`DATA_W-1:0] addrOut;
	logic [`DATA_W-1:0] dataOut;
	logic dataWe;
	logic [`DATA_W-1:0] acc;
	logic [`DATA_W-1:0] regX;
	logic [`DATA_W-1:0] regY;
	logic [`DATA_W-1:0] sp;
	logic [2*`DATA_W-1:0] pc;
	logic [`DATA_W-1:0] status;

	logic [15:0] lfsr;
	int cycle = 0;
	int checks = 0;
	int valueErrors = 0;
	modelState_s model;
	modelState_s expNow;
	string nameNow;
	modelState_s expQ[$];
	string nameQ[$];
	int dueQ[$];

	datapathTop uut (
		.ld(ld), .rstN(rstN), .cmdStrobe(cmdStrobe), .cmd(cmd), .dataIn(dataIn),
		.addrOut(addrOut), .dataOut(dataOut), .dataWe(dataWe), .acc(acc), .regX(regX),
		.regY(regY), .sp(sp), .pc(pc), .status(status)
	);

	always #5 ld = ~ld;

	// taps of x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at bit 0
	function automatic logic [15:0] nextLfsr(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one LFSR step per bit taken
	function automatic logic [7:0] randBits(input int count);
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < count; i++) begin
			lfsr = nextLfsr(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] randBcd();
		logic [7:0] hi;
		logic [7:0] lo;
		hi = randBits(4);
		lo = randBits(4);
		// fold 10..15 back into a digit
		if (hi > 8'd9)
			hi = hi - 8'd10;
		if (lo > 8'd9)
			lo = lo - 8'd10;
		return {hi[3:0], lo[3:0]};
	endfunction

	function automatic int bcdValue(input logic [7:0] v);
		return int'(v[7:4]) * 10 + int'(v[3:0]);
	endfunction

	function automatic logic [7:0] bcdByte(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	function automatic cmdWord_u packAlu(aluOp_e op, srcSel_e src, logic [7:0] imm);
		cmdWord_u c;
		c.alu.kind = KIND_ALU;
		c.alu.aluOp = op;
		c.alu.srcSel = src;
		c.alu.spare = 1'b0;
		c.alu.imm = imm;
		return c;
	endfunction

	function automatic cmdWord_u packOther(cmdKind_e kind, logic [1:0] sub, regSel_e dst,
			srcSel_e src, logic [7:0] imm);
		cmdWord_u c;
		c.xfer.kind = kind;
		c.xfer.subOp = sub;
		c.xfer.dstReg = dst;
		c.xfer.srcSel = src;
		c.xfer.imm = imm;
		return c;
	endfunction

	function automatic logic [7:0] regValue(modelState_s s, regSel_e r);
		case (r)
			REG_A: return s.acc;
			REG_X: return s.x;
			REG_Y: return s.y;
			default: return s.sp;
		endcase
	endfunction

	// imm, data bus, X or Y
	function automatic logic [7:0] pickSource(modelState_s s, srcSel_e src, logic [7:0] imm,
			logic [7:0] din);
		case (src)
			SRC_IMM: return imm;
			SRC_DATA: return din;
			SRC_X: return s.x;
			default: return s.y;
		endcase
	endfunction

	// next architectural state for one command
	function automatic modelState_s refStep(modelState_s s, cmdWord_u c, logic [7:0] din);
		modelState_s n;
		logic [7:0] opnd;
		logic [7:0] b;
		logic [8:0] sum;
		logic [7:0] r;
		logic cOut;
		logic wr;
		int dec;
		n = s;
		n.we = 1'b0;
		r = 8'h00;
		wr = 1'b0;
		case (c.alu.kind)
			KIND_ALU: begin
				opnd = pickSource(s, c.alu.srcSel, c.alu.imm, din);
				// subtract adds the complement with C as not-borrow
				b = (c.alu.aluOp == OP_SBC) ? ~opnd : opnd;
				sum = {1'b0, s.acc} + {1'b0, b} + {8'h00, s.status[0]};
				r = sum[7:0];
				cOut = sum[8];
				case (c.alu.aluOp)
					OP_ADC: begin
						// true BCD sum when D is set
						if (s.status[3]) begin
							dec = bcdValue(s.acc) + bcdValue(opnd) + int'(s.status[0]);
							cOut = (dec > 99);
							r = bcdByte(dec % 100);
						end
					end
					OP_AND: r = s.acc & opnd;
					OP_EOR: r = s.acc ^ opnd;
					OP_ORA: r = s.acc | opnd;
					OP_LSR: r = {1'b0, s.acc[7:1]};
					default: ;
				endcase
				if (c.alu.aluOp == OP_AND || c.alu.aluOp == OP_EOR || c.alu.aluOp == OP_ORA)
					cOut = s.status[0];
				if (c.alu.aluOp == OP_LSR)
					cOut = s.acc[0];
				n.acc = r;
				n.status[7] = r[7];
				n.status[1] = (r == 8'h00);
				n.status[0] = cOut;
				// V follows the binary sum even in decimal mode
				if (c.alu.aluOp == OP_ADC || c.alu.aluOp == OP_SBC)
					n.status[6] = (s.acc[7] == b[7]) && (sum[7] != s.acc[7]);
			end
			KIND_XFER: begin
				wr = 1'b1;
				case (c.xfer.subOp)
					XF_LOAD: r = pickSource(s, c.xfer.srcSel, c.xfer.imm, din);
					XF_FROM_A: r = s.acc;
					XF_FROM_S: r = s.sp;
					default: wr = 1'b0;
				endcase
			end
			KIND_MEM: begin
				case (c.xfer.subOp)
					MEM_STORE: begin
						n.we = 1'b1;
						n.addr = {c.xfer.imm, s.x};
						n.dout = regValue(s, c.xfer.dstReg);
					end
					MEM_PUSH: begin
						n.we = 1'b1;
						n.addr = {`STACK_PAGE, s.sp};
						n.dout = regValue(s, c.xfer.dstReg);
						n.sp = s.sp - 8'd1;
					end
					MEM_PULL: begin
						n.sp = s.sp + 8'd1;
						r = din;
						wr = 1'b1;
					end
					default: ;
				endcase
			end
			default: begin
				// imm bit 0 is C, bit 1 is D, bit 2 is V
				case (c.xfer.subOp)
					FL_INC: n.pc = s.pc + 16'd1;
					FL_JUMP: n.pc = {din, c.xfer.imm};
					FL_SET: begin
						n.status[0] = s.status[0] | c.xfer.imm[0];
						n.status[3] = s.status[3] | c.xfer.imm[1];
					end
					default: begin
						n.status[0] = s.status[0] & ~c.xfer.imm[0];
						n.status[3] = s.status[3] & ~c.xfer.imm[1];
						n.status[6] = s.status[6] & ~c.xfer.imm[2];
					end
				endcase
			end
		endcase
		if (wr) begin
			// a written S also overrides the pull step
			case (c.xfer.dstReg)
				REG_A: n.acc = r;
				REG_X: n.x = r;
				REG_Y: n.y = r;
				default: n.sp = r;
			endcase
			if (c.xfer.dstReg != REG_S) begin
				n.status[7] = r[7];
				n.status[1] = (r == 8'h00);
			end
		end
		return n;
	endfunction

	task automatic checkByte(input string test, input string what, input logic [7:0] e,
			input logic [7:0] a);
		checks++;
		if (a !== e) begin
			$display("FAIL %s %s: expected %02h, actual %02h", test, what, e, a);
			valueErrors++;
		end
	endtask

	task automatic checkWord(input string test, input string what, input logic [15:0] e,
			input logic [15:0] a);
		checks++;
		if (a !== e) begin
			$display("FAIL %s %s: expected %04h, actual %04h", test, what, e, a);
			valueErrors++;
		end
	endtask

	task automatic checkStatus(input string test, input logic [7:0] e, input logic [7:0] a);
		checks++;
		if (a !== e) begin
			$display("FAIL %s status: expected %02h (NV11DIZC %08b), actual %02h (%08b)",
				test, e, e, a, a);
			valueErrors++;
		end
	endtask

	task automatic checkBit(input string test, input string what, input logic e, input logic a);
		checks++;
		if (a !== e) begin
			$display("FAIL %s %s: expected %0b, actual %0b", test, what, e, a);
			valueErrors++;
		end
	endtask

	// driven on the falling edge with the expected state due one cycle later
	task automatic sendCmd(input string name, input cmdWord_u c, input logic [7:0] din);
		cmd = c;
		dataIn = din;
		cmdStrobe = 1'b1;
		model = refStep(model, c, din);
		expQ.push_back(model);
		nameQ.push_back(name);
		dueQ.push_back(cycle + 1);
		@(negedge ld);
	endtask

	always @(posedge ld) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the command sequence did not complete", cycle);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// registered outputs are stable at the falling edge
	always @(negedge ld) begin
		if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
			expNow = expQ.pop_front();
			nameNow = nameQ.pop_front();
			void'(dueQ.pop_front());
			checkByte(nameNow, "acc", expNow.acc, acc);
			checkByte(nameNow, "regX", expNow.x, regX);
			checkByte(nameNow, "regY", expNow.y, regY);
			checkByte(nameNow, "sp", expNow.sp, sp);
			checkWord(nameNow, "pc", expNow.pc, pc);
			checkStatus(nameNow, expNow.status, status);
			checkBit(nameNow, "dataWe", expNow.we, dataWe);
			if (expNow.we) begin
				checkWord(nameNow, "addrOut", expNow.addr, addrOut);
				checkByte(nameNow, "dataOut", expNow.dout, dataOut);
			end
		end
	end

	initial begin
		logic [7:0] v;
		logic [7:0] src;
		logic [7:0] immB;
		logic [7:0] dinB;
		ld = 1'b0;
		rstN = 1'b0;
		cmdStrobe = 1'b0;
		cmd = '0;
		dataIn = 8'h00;
		lfsr = 16'd59;
		// B and bit 5 read as 1
		model = '0;
		model.sp = 8'hFF;
		model.pc = `RESET_PC;
		model.status = `RESET_P | 8'h30;
		repeat (5) @(posedge ld);
		@(negedge ld);
		rstN = 1'b1;
		// the sequencer arms one edge after reset release
		@(negedge ld);
		checkByte("reset", "acc", 8'h00, acc);
		checkByte("reset", "regX", 8'h00, regX);
		checkByte("reset", "regY", 8'h00, regY);
		checkByte("reset", "sp", 8'hFF, sp);
		checkWord("reset", "pc", `RESET_PC, pc);
		checkStatus("reset", `RESET_P | 8'h30, status);
		checkBit("reset", "dataWe", 1'b0, dataWe);

		// random ALU ops after X and Y are loaded
		sendCmd("binary alu", packOther(KIND_XFER, XF_LOAD, REG_X, SRC_IMM, randBits(8)), 8'h00);
		sendCmd("binary alu", packOther(KIND_XFER, XF_LOAD, REG_Y, SRC_DATA, 8'h00), randBits(8));
		for (int i = 0; i < NUM_BIN; i++) begin
			v = randBits(3);
			if (v > 8'd5)
				v = v - 8'd6;
			src = randBits(2);
			immB = randBits(8);
			dinB = randBits(8);
			sendCmd("binary alu", packAlu(aluOp_e'(v[2:0]), srcSel_e'(src[1:0]), immB), dinB);
		end

		// BCD add with random carry in
		sendCmd("decimal", packOther(KIND_FLOW, FL_SET, REG_A, SRC_IMM, 8'h02), 8'h00);
		for (int i = 0; i < NUM_DEC; i++) begin
			sendCmd("decimal", packOther(KIND_XFER, XF_LOAD, REG_A, SRC_IMM, randBcd()), 8'h00);
			v = randBits(1);
			sendCmd("decimal", packOther(KIND_FLOW, v[0] ? FL_SET : FL_CLR, REG_A, SRC_IMM,
				8'h01), 8'h00);
			sendCmd("decimal adc", packAlu(OP_ADC, SRC_IMM, randBcd()), 8'h00);
		end
		sendCmd("decimal sbc", packAlu(OP_SBC, SRC_IMM, randBcd()), 8'h00);
		sendCmd("decimal", packOther(KIND_FLOW, FL_CLR, REG_A, SRC_IMM, 8'h03), 8'h00);

		// loads and copies where S writes keep the flags
		sendCmd("transfer", packOther(KIND_XFER, XF_LOAD, REG_A, SRC_IMM, 8'h00), 8'h00);
		sendCmd("transfer", packOther(KIND_XFER, XF_LOAD, REG_X, SRC_IMM, 8'h80), 8'h00);
		sendCmd("transfer", packOther(KIND_XFER, XF_LOAD, REG_Y, SRC_DATA, 8'h00), 8'h5A);
		sendCmd("transfer", packOther(KIND_XFER, XF_LOAD, REG_A, SRC_X, 8'h00), 8'h00);
		sendCmd("transfer", packOther(KIND_XFER, XF_LOAD, REG_X, SRC_Y, 8'h00), 8'h00);
		sendCmd("transfer", packOther(KIND_XFER, XF_FROM_A, REG_S, SRC_IMM, 8'h00), 8'h00);
		sendCmd("transfer", packOther(KIND_XFER, XF_LOAD, REG_S, SRC_IMM, 8'hFF), 8'h00);
		sendCmd("transfer", packOther(KIND_XFER, XF_FROM_S, REG_Y, SRC_IMM, 8'h00), 8'h00);

		// store, pushes and pulls with a flow command in between to drop dataWe
		sendCmd("memory", packOther(KIND_XFER, XF_LOAD, REG_A, SRC_IMM, 8'hC3), 8'h00);
		sendCmd("memory", packOther(KIND_MEM, MEM_STORE, REG_A, SRC_IMM, 8'h30), 8'h00);
		sendCmd("memory", packOther(KIND_FLOW, FL_INC, REG_A, SRC_IMM, 8'h00), 8'h00);
		sendCmd("memory", packOther(KIND_MEM, MEM_PUSH, REG_A, SRC_IMM, 8'h00), 8'h00);
		sendCmd("memory", packOther(KIND_MEM, MEM_PUSH, REG_X, SRC_IMM, 8'h00), 8'h00);
		sendCmd("memory", packOther(KIND_MEM, MEM_PULL, REG_Y, SRC_IMM, 8'h00), 8'h00);
		sendCmd("memory", packOther(KIND_MEM, MEM_PULL, REG_A, SRC_IMM, 8'h00), 8'h9E);
		sendCmd("memory", packOther(KIND_MEM, MEM_STORE, REG_Y, SRC_IMM, 8'h12), 8'h00);
		sendCmd("memory", packOther(KIND_MEM, MEM_PUSH, REG_Y, SRC_IMM, 8'h00), 8'h00);

		// pc wrap, jumps and flag set/clear
		sendCmd("flow", packOther(KIND_FLOW, FL_JUMP, REG_A, SRC_IMM, 8'hFF), 8'hFF);
		sendCmd("flow", packOther(KIND_FLOW, FL_INC, REG_A, SRC_IMM, 8'h00), 8'h00);
		sendCmd("flow", packOther(KIND_FLOW, FL_INC, REG_A, SRC_IMM, 8'h00), 8'h00);
		sendCmd("flow", packOther(KIND_FLOW, FL_JUMP, REG_A, SRC_IMM, 8'h34), 8'h12);
		sendCmd("flow", packOther(KIND_FLOW, FL_SET, REG_A, SRC_IMM, 8'h01), 8'h00);
		sendCmd("flow", packOther(KIND_FLOW, FL_CLR, REG_A, SRC_IMM, 8'h01), 8'h00);
		sendCmd("flow", packOther(KIND_FLOW, FL_SET, REG_A, SRC_IMM, 8'h02), 8'h00);
		sendCmd("flow", packOther(KIND_FLOW, FL_CLR, REG_A, SRC_IMM, 8'h02), 8'h00);
		sendCmd("flow", packOther(KIND_XFER, XF_LOAD, REG_A, SRC_IMM, 8'h7F), 8'h00);
		sendCmd("flow", packAlu(OP_ADC, SRC_IMM, 8'h01), 8'h00);
		sendCmd("flow", packOther(KIND_FLOW, FL_CLR, REG_A, SRC_IMM, 8'h04), 8'h00);
		sendCmd("flow", packOther(KIND_FLOW, FL_SET, REG_A, SRC_IMM, 8'h03), 8'h00);
		sendCmd("flow", packOther(KIND_FLOW, FL_CLR, REG_A, SRC_IMM, 8'h07), 8'h00);

		cmdStrobe = 1'b0;
		while (dueQ.size() != 0)
			@(negedge ld);
		$display("checks %0d, value errors %0d", checks, valueErrors);
		if (valueErrors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/dpPkg.sv
verilog/microSequencer.sv
verilog/aluUnit.sv
verilog/regBank.sv
verilog/pcUnit.sv
verilog/statusReg.sv
verilog/datapathTop.sv
testbench/tbDatapath.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and reports the result through the exit status
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module tbDatapath -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VtbDatapath > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
